// ==== flist.f ====
logic/board_pkg.sv
logic/lbs_ctrl.sv
logic/sys_registers.sv
logic/timer.sv
logic/pwm_ctrl.sv
logic/ad7606_ctrl.sv
logic/control_board.sv
tests/ad7606_model.sv
tests/control_board_tb.sv

// ==== tests/control_board_tb.sv ====
/*
 * Board controller testbench with bus tasks, register table,
 * PWM, AD7606 and timer checks
 */
`timescale 1ns/1ps
module control_board_tb
    import board_pkg::*;
();

    localparam int         NUM_OPS      = 16;
    localparam int         PWM_WINDOW   = 160;
    localparam int         PWM_HIGH_EXP = PWM_WINDOW / 2;    // Duty word is half the range
    localparam int         POLL_LIMIT   = 100;
    localparam int         RESET_LIMIT  = 4;
    localparam int         TIMER_LIMIT  = 20000 + 500;
    localparam logic [5:0] TTL_PATTERN  = 6'h29;
    localparam logic       OP_RD        = 1'b0;
    localparam logic       OP_WR        = 1'b1;

    typedef struct packed {
        logic      wr;
        lbs_addr_t addr;
        lbs_data_t wdata;
        lbs_data_t exp;
    } bus_op_t;

    logic       clk;
    logic       reset_i;
    logic       lbs_cs_n_i;
    logic       lbs_we_i;
    logic       lbs_re_i;
    lbs_addr_t  lbs_addr_i;
    lbs_data_t  lbs_wdata_i;
    lbs_data_t  lbs_rdata_o;
    logic [3:0] relay_con_o;
    logic       relay_oen_o;
    logic [5:0] ttl_i;
    logic [5:0] ttl_o;
    logic       ttl_en_o;
    logic       run_o;
    logic       speak_o;
    logic       ad_busy;
    logic       ad_frstdata;
    ad_sample_t ad_data;
    logic       ad_csn;
    logic       ad_rd;
    logic       ad_convst_a;
    logic       ad_convst_b;
    logic       ad_reset;
    logic [2:0] ad_os;
    logic       ad_range;
    logic       ad_ref_sel;

    bus_op_t    ops [NUM_OPS];
    ad_sample_t chan_vals [2*AD_CHANNELS];     // Two frames of model data
    int         data_errs;
    int         sample_errs;
    int         bit_errs;
    int         timeout_errs;
    int         cycle_cnt;

    control_board #(
        .CLK_PER_MS (20)
    ) UUT (
        .clk           (clk),
        .reset_i       (reset_i),
        .lbs_cs_n_i    (lbs_cs_n_i),
        .lbs_we_i      (lbs_we_i),
        .lbs_re_i      (lbs_re_i),
        .lbs_addr_i    (lbs_addr_i),
        .lbs_wdata_i   (lbs_wdata_i),
        .lbs_rdata_o   (lbs_rdata_o),
        .relay_con_o   (relay_con_o),
        .relay_oen_o   (relay_oen_o),
        .ttl_i         (ttl_i),
        .ttl_o         (ttl_o),
        .ttl_en_o      (ttl_en_o),
        .run_o         (run_o),
        .speak_o       (speak_o),
        .ad_busy_i     (ad_busy),
        .ad_frstdata_i (ad_frstdata),
        .ad_data_i     (ad_data),
        .ad_csn_o      (ad_csn),
        .ad_rd_o       (ad_rd),
        .ad_convst_a_o (ad_convst_a),
        .ad_convst_b_o (ad_convst_b),
        .ad_reset_o    (ad_reset),
        .ad_os_o       (ad_os),
        .ad_range_o    (ad_range),
        .ad_ref_sel_o  (ad_ref_sel)
    );

    ad7606_model u_adc (
        .clk        (clk),
        .reset_i    (reset_i || ad_reset),
        .convst_i   (ad_convst_a),
        .csn_i      (ad_csn),
        .rd_i       (ad_rd),
        .busy_o     (ad_busy),
        .frstdata_o (ad_frstdata),
        .data_o     (ad_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = !clk;
    end

    // Cycles since reset release
    always @(posedge clk)
    begin
        if (reset_i)
            cycle_cnt <= 0;
        else
            cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // ********************
    // Compare tasks
    // ********************
    task automatic check_data(input string name, input lbs_data_t got, input lbs_data_t exp);
        if (got !== exp)
        begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            data_errs++;
        end
    endtask

    task automatic check_sample(input string name, input ad_sample_t got, input ad_sample_t exp);
        if (got !== exp)
        begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            sample_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            bit_errs++;
        end
    endtask

    // ********************
    // Bus access
    // ********************
    // Register changes two edges after the strobe edge
    task automatic bus_write(input lbs_addr_t addr, input lbs_data_t data);
        @(posedge clk);
        lbs_cs_n_i  <= 1'b0;
        lbs_we_i    <= 1'b1;
        lbs_addr_i  <= addr;
        lbs_wdata_i <= data;
        @(posedge clk);
        lbs_cs_n_i  <= 1'b1;
        lbs_we_i    <= 1'b0;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic bus_read(input lbs_addr_t addr, output lbs_data_t data);
        @(posedge clk);
        lbs_cs_n_i <= 1'b0;
        lbs_re_i   <= 1'b1;
        lbs_addr_i <= addr;
        @(posedge clk);
        lbs_cs_n_i <= 1'b1;
        lbs_re_i   <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        data = lbs_rdata_o;
    endtask

    task automatic apply_op(input bus_op_t op);
        lbs_data_t rd;
        if (op.wr == OP_WR)
        begin
            bus_write(op.addr, op.wdata);
            if (op.addr == REG_RELAY)
            begin
                check_data("relay_con_o", {12'd0, relay_con_o}, {12'd0, op.wdata[3:0]});
                check_bit("relay_oen_o", relay_oen_o, op.wdata[4]);
            end
            else if (op.addr == REG_TTL_OUT)
            begin
                check_data("ttl_o", {10'd0, ttl_o}, {10'd0, op.wdata[5:0]});
                check_bit("ttl_en_o", ttl_en_o, op.wdata[8]);
            end
        end
        else
        begin
            bus_read(op.addr, rd);
            check_data($sformatf("lbs_rdata_o at 0x%h", op.addr), rd, op.exp);
        end
    endtask

    task automatic build_table();
        ops[0]  = '{OP_RD, REG_ID,      16'h0000, BOARD_ID};
        ops[1]  = '{OP_RD, REG_RELAY,   16'h0000, 16'h0000};
        ops[2]  = '{OP_RD, REG_TTL_OUT, 16'h0000, 16'h0000};
        ops[3]  = '{OP_WR, REG_RELAY,   16'h0015, 16'h0000};
        ops[4]  = '{OP_RD, REG_RELAY,   16'h0000, 16'h0015};
        ops[5]  = '{OP_WR, REG_RELAY,   16'hFFEA, 16'h0000};
        ops[6]  = '{OP_RD, REG_RELAY,   16'h0000, 16'h000A};   // Upper bits dropped
        ops[7]  = '{OP_WR, REG_TTL_OUT, 16'h012D, 16'h0000};
        ops[8]  = '{OP_RD, REG_TTL_OUT, 16'h0000, 16'h012D};
        ops[9]  = '{OP_WR, REG_TTL_OUT, 16'hFEFF, 16'h0000};
        ops[10] = '{OP_RD, REG_TTL_OUT, 16'h0000, 16'h003F};
        ops[11] = '{OP_RD, REG_TTL_IN,  16'h0000, {10'd0, TTL_PATTERN}};
        ops[12] = '{OP_RD, REG_AD_CTRL, 16'h0000, 16'h0000};
        ops[13] = '{OP_WR, REG_DUTY_LO, 16'hBEEF, 16'h0000};
        ops[14] = '{OP_RD, REG_DUTY_LO, 16'h0000, 16'hBEEF};
        ops[15] = '{OP_RD, 8'h3C,       16'h0000, 16'h0000};   // Unmapped
    endtask

    // ********************
    // AD7606 helpers
    // ********************
    task automatic load_model(input int set);
        int n;
        for (n = 0; n < AD_CHANNELS; n++)
            u_adc.load_sample(n, chan_vals[set*AD_CHANNELS + n]);
    endtask

    // Converter reset pin reaches the written level within a few cycles
    task automatic follow_ad_reset(input logic level);
        int waited;
        waited = 0;
        while (ad_reset !== level && waited < RESET_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        check_bit("ad_reset_o", ad_reset, level);
    endtask

    task automatic wait_for_samples(input int set);
        lbs_data_t got [AD_CHANNELS];
        int        polls;
        int        n;
        logic      match;
        polls = 0;
        match = 1'b0;
        while (!match && polls < POLL_LIMIT)
        begin
            match = 1'b1;
            for (n = 0; n < AD_CHANNELS; n++)
            begin
                bus_read(lbs_addr_t'((1 << AD_PAGE_BIT) | n), got[n]);
                if (got[n] !== chan_vals[set*AD_CHANNELS + n])
                    match = 1'b0;
            end
            polls++;
        end
        if (!match)
        begin
            $display("Timeout: AD7606 channel registers never showed sample set %0d", set);
            timeout_errs++;
        end
        for (n = 0; n < AD_CHANNELS; n++)
            check_sample($sformatf("AD channel %0d", n), got[n], chan_vals[set*AD_CHANNELS + n]);
    endtask

    // ********************
    // Main sequence
    // ********************
    initial
    begin
        lbs_data_t   rd;
        logic [31:0] seed;
        int          highs;
        int          i;
        reset_i      = 1'b1;
        lbs_cs_n_i   = 1'b1;
        lbs_we_i     = 1'b0;
        lbs_re_i     = 1'b0;
        lbs_addr_i   = '0;
        lbs_wdata_i  = '0;
        ttl_i        = '0;
        data_errs    = 0;
        sample_errs  = 0;
        bit_errs     = 0;
        timeout_errs = 0;
        seed         = 32'd18954;
        for (i = 0; i < 2*AD_CHANNELS; i++)
        begin
            seed         = next_random(seed);
            chan_vals[i] = seed[31:16];
        end
        build_table();
        load_model(0);

        repeat (10) @(posedge clk);
        reset_i <= 1'b0;
        ttl_i   <= TTL_PATTERN;
        @(negedge clk);

        // Outputs straight after reset
        check_data("relay_con_o", {12'd0, relay_con_o}, 16'h0000);
        check_bit("relay_oen_o", relay_oen_o, 1'b0);
        check_data("ttl_o", {10'd0, ttl_o}, 16'h0000);
        check_bit("ttl_en_o", ttl_en_o, 1'b0);
        check_bit("speak_o", speak_o, 1'b0);
        check_bit("run_o", run_o, 1'b0);
        check_bit("ad_csn_o", ad_csn, 1'b1);
        check_bit("ad_rd_o", ad_rd, 1'b1);
        check_bit("ad_convst_a_o", ad_convst_a, 1'b1);
        check_bit("ad_convst_b_o", ad_convst_b, 1'b1);
        check_bit("ad_reset_o", ad_reset, 1'b0);

        // Converter setup pins are fixed
        check_data("ad_os_o", {13'd0, ad_os}, 16'h0000);
        check_bit("ad_range_o", ad_range, 1'b1);
        check_bit("ad_ref_sel_o", ad_ref_sel, 1'b1);

        for (i = 0; i < NUM_OPS; i++)
            apply_op(ops[i]);

        // PWM at 1/16 of the clock, half duty
        bus_write(REG_FTW_LO, 16'h0000);
        bus_write(REG_FTW_HI, 16'h1000);
        bus_write(REG_DUTY_LO, 16'h0000);
        bus_write(REG_DUTY_HI, 16'h8000);
        bus_write(REG_PWM_CTRL, 16'h0002);     // Load only
        bus_write(REG_PWM_CTRL, 16'h0001);
        repeat (2) @(negedge clk);
        highs = 0;
        repeat (PWM_WINDOW)
        begin
            @(negedge clk);
            if (speak_o)
                highs++;
        end
        check_data("speak_o high cycles", lbs_data_t'(highs), lbs_data_t'(PWM_HIGH_EXP));
        bus_write(REG_PWM_CTRL, 16'h0000);
        @(negedge clk);
        highs = 0;
        repeat (32)
        begin
            @(negedge clk);
            if (speak_o)
                highs++;
        end
        check_data("speak_o high cycles when disabled", lbs_data_t'(highs), 16'h0000);

        // Converter reset level set and cleared
        bus_write(REG_AD_CTRL, 16'h0001);
        follow_ad_reset(1'b1);
        bus_write(REG_AD_CTRL, 16'h0000);
        follow_ad_reset(1'b0);

        // Conversions every millisecond
        bus_write(REG_AD_CTRL, 16'h0002);
        wait_for_samples(0);
        load_model(1);
        wait_for_samples(1);

        // Run indicator after 1000 ms pulses
        while (run_o !== 1'b1 && cycle_cnt < TIMER_LIMIT)
            @(negedge clk);
        if (run_o !== 1'b1)
        begin
            $display("Timeout: run_o did not toggle within %0d cycles of reset", TIMER_LIMIT);
            timeout_errs++;
        end
        else
        begin
            bus_read(REG_SEC_CNT, rd);
            if (rd == 16'h0000 || $isunknown(rd))
            begin
                $display("[FAIL] REG_SEC_CNT: got 0x%h, expected 0x0001 or more", rd);
                data_errs++;
            end
        end

        $display("Errors: data %0d, sample %0d, bit %0d, timeout %0d",
                 data_errs, sample_errs, bit_errs, timeout_errs);
        if (data_errs + sample_errs + bit_errs + timeout_errs == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== tests/ad7606_model.sv ====
/*
 * Behavioral AD7606: busy after convst, parallel read of a channel table
 */
`timescale 1ns/1ps
module ad7606_model
    import board_pkg::*;
#(
    parameter int CONV_CYCLES = 12
)
(
    input  logic       clk,
    input  logic       reset_i,
    input  logic       convst_i,
    input  logic       csn_i,
    input  logic       rd_i,
    output logic       busy_o,
    output logic       frstdata_o,
    output ad_sample_t data_o
);

    ad_sample_t samples [AD_CHANNELS];
    logic       convst_q;
    logic       rd_q;
    int         busy_cnt;
    int         idx;                        // Channel on the data pins

    // Table entry for channel n
    task automatic load_sample(input int n, input ad_sample_t value);
        samples[n] = value;
    endtask

    always @(posedge clk)
    begin
        convst_q <= convst_i;
        rd_q     <= rd_i;
        if (reset_i)
        begin
            busy_o   <= 1'b0;
            busy_cnt <= 0;
            idx      <= 0;
        end
        else if (!convst_q && convst_i)     // Rising convst starts a conversion
        begin
            busy_o   <= 1'b1;
            busy_cnt <= CONV_CYCLES;
            idx      <= 0;
        end
        else
        begin
            if (busy_cnt > 0)
                busy_cnt <= busy_cnt - 1;
            if (busy_cnt == 1)
                busy_o <= 1'b0;
            // Next channel after each read pulse
            if (!rd_q && rd_i)
                idx <= idx + 1;
        end
    end

    assign data_o     = (idx < AD_CHANNELS) ? samples[idx] : '0;
    assign frstdata_o = (idx == 0) && !csn_i;

endmodule

// ==== logic/control_board.sv ====
/*
 * Board controller top: local bus decode, system registers,
 * timer, speaker PWM and AD7606 controller
 */
`timescale 1ns/1ps
module control_board
    import board_pkg::*;
#(
    parameter int CLK_PER_MS = 80000
)
(
    input  logic       clk,
    input  logic       reset_i,
    input  logic       lbs_cs_n_i,
    input  logic       lbs_we_i,
    input  logic       lbs_re_i,
    input  lbs_addr_t  lbs_addr_i,
    input  lbs_data_t  lbs_wdata_i,
    output lbs_data_t  lbs_rdata_o,
    output logic [3:0] relay_con_o,
    output logic       relay_oen_o,
    input  logic [5:0] ttl_i,
    output logic [5:0] ttl_o,
    output logic       ttl_en_o,
    output logic       run_o,
    output logic       speak_o,
    input  logic       ad_busy_i,
    input  logic       ad_frstdata_i,
    input  ad_sample_t ad_data_i,
    output logic       ad_csn_o,
    output logic       ad_rd_o,
    output logic       ad_convst_a_o,
    output logic       ad_convst_b_o,
    output logic       ad_reset_o,
    output logic [2:0] ad_os_o,
    output logic       ad_range_o,
    output logic       ad_ref_sel_o
);

    lbs_addr_t reg_addr;
    lbs_data_t reg_wdata;
    logic      reg_we;
    logic      sys_sel;
    logic      ad_sel;
    lbs_data_t sys_rdata;
    lbs_data_t ad_rdata;
    phase_t    pwm_ftw;
    phase_t    pwm_duty;
    logic      pwm_en;
    logic      pwm_load;
    logic      ad_conv_en;
    logic      ad_reset;
    logic      ms_pulse;
    logic      second_tick;
    logic      ad_convst;

    lbs_ctrl u_lbs_ctrl (
        .clk         (clk          ),
        .reset_i     (reset_i      ),
        .lbs_cs_n_i  (lbs_cs_n_i   ),
        .lbs_we_i    (lbs_we_i     ),
        .lbs_re_i    (lbs_re_i     ),
        .lbs_addr_i  (lbs_addr_i   ),
        .lbs_wdata_i (lbs_wdata_i  ),
        .sys_rdata_i (sys_rdata    ),
        .ad_rdata_i  (ad_rdata     ),
        .reg_addr_o  (reg_addr     ),
        .reg_wdata_o (reg_wdata    ),
        .reg_we_o    (reg_we       ),
        .sys_sel_o   (sys_sel      ),
        .ad_sel_o    (ad_sel       ),
        .lbs_rdata_o (lbs_rdata_o  )
    );

    sys_registers u_sys_registers (
        .clk           (clk          ),
        .reset_i       (reset_i      ),
        .reg_addr_i    (reg_addr     ),
        .reg_wdata_i   (reg_wdata    ),
        .reg_we_i      (reg_we       ),
        .sel_i         (sys_sel      ),
        .ttl_i         (ttl_i        ),
        .second_tick_i (second_tick  ),
        .rdata_o       (sys_rdata    ),
        .relay_con_o   (relay_con_o  ),
        .relay_oen_o   (relay_oen_o  ),
        .ttl_o         (ttl_o        ),
        .ttl_en_o      (ttl_en_o     ),
        .pwm_ftw_o     (pwm_ftw      ),
        .pwm_duty_o    (pwm_duty     ),
        .pwm_en_o      (pwm_en       ),
        .pwm_load_o    (pwm_load     ),
        .ad_conv_en_o  (ad_conv_en   ),
        .ad_reset_o    (ad_reset     )
    );

    timer #(
        .CLK_PER_MS    (CLK_PER_MS   )
    ) u_timer (
        .clk           (clk          ),
        .reset_i       (reset_i      ),
        .ms_pulse_o    (ms_pulse     ),
        .second_tick_o (second_tick  ),
        .run_o         (run_o        )
    );

    pwm_ctrl u_pwm_ctrl (
        .clk     (clk      ),
        .reset_i (reset_i  ),
        .ftw_i   (pwm_ftw  ),
        .duty_i  (pwm_duty ),
        .en_i    (pwm_en   ),
        .load_i  (pwm_load ),
        .pwm_o   (speak_o  )           // Speaker drive
    );

    ad7606_ctrl u_ad7606_ctrl (
        .clk        (clk           ),
        .reset_i    (reset_i       ),
        .ms_pulse_i (ms_pulse      ),
        .conv_en_i  (ad_conv_en    ),
        .ad_reset_i (ad_reset      ),
        .busy_i     (ad_busy_i     ),
        .frstdata_i (ad_frstdata_i ),
        .data_i     (ad_data_i     ),
        .reg_addr_i (reg_addr      ),
        .sel_i      (ad_sel        ),
        .rdata_o    (ad_rdata      ),
        .csn_o      (ad_csn_o      ),
        .rd_o       (ad_rd_o       ),
        .convst_o   (ad_convst     ),
        .ad_reset_o (ad_reset_o    )
    );

    // Both conversion groups start together
    assign ad_convst_a_o = ad_convst;
    assign ad_convst_b_o = ad_convst;

    // Static converter setup
    assign ad_os_o      = AD_OS_SETTING;
    assign ad_range_o   = AD_RANGE_SETTING;
    assign ad_ref_sel_o = AD_REF_SETTING;

endmodule

// ==== logic/ad7606_ctrl.sv ====
/*
 * AD7606 conversion and parallel read sequencer,
 * channel data registers on the AD page
 */
`timescale 1ns/1ps
module ad7606_ctrl
    import board_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,
    input  logic       ms_pulse_i,
    input  logic       conv_en_i,
    input  logic       ad_reset_i,
    input  logic       busy_i,
    input  logic       frstdata_i,
    input  ad_sample_t data_i,
    input  lbs_addr_t  reg_addr_i,
    input  logic       sel_i,
    output lbs_data_t  rdata_o,
    output logic       csn_o,
    output logic       rd_o,
    output logic       convst_o,
    output logic       ad_reset_o
);

    ad_state_t                       state;
    logic [$clog2(BUSY_TIMEOUT)-1:0] cnt;
    ad_chan_t                        chan;
    logic                            frst_ok;   // Frame aligned to channel 0
    logic                            sample_en;
    ad_sample_t                      shadow [AD_CHANNELS];
    ad_sample_t                      chan_q [AD_CHANNELS];

    // Last low cycle of a read pulse
    assign sample_en = (state == RD_LOW) && (cnt == RD_LOW_CYCLES - 1);

    // ********************
    // Sequencer
    // ********************
    always_ff @(posedge clk)
    begin
        if (reset_i || ad_reset_i)
        begin
            state   <= IDLE;
            cnt     <= '0;
            chan    <= '0;
            frst_ok <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    cnt  <= '0;
                    chan <= '0;
                    if (ms_pulse_i && conv_en_i)
                        state <= CONVST;
                end
                CONVST:
                begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CONVST_LOW_CYCLES - 1)
                    begin
                        cnt   <= '0;
                        state <= WAIT_BUSY_HI;
                    end
                end
                WAIT_BUSY_HI:
                begin
                    cnt <= cnt + 1'b1;
                    if (busy_i)
                    begin
                        cnt   <= '0;
                        state <= WAIT_BUSY_LO;
                    end
                    else if (cnt == BUSY_TIMEOUT - 1)
                        state <= IDLE;          // Converter never started
                end
                WAIT_BUSY_LO:
                begin
                    cnt <= cnt + 1'b1;
                    if (!busy_i)
                    begin
                        cnt   <= '0;
                        state <= RD_LOW;
                    end
                    else if (cnt == BUSY_TIMEOUT - 1)
                        state <= IDLE;
                end
                RD_LOW:
                begin
                    cnt <= cnt + 1'b1;
                    if (sample_en)
                    begin
                        cnt   <= '0;
                        state <= RD_HIGH;
                        if (chan == '0)
                            frst_ok <= frstdata_i;
                    end
                end
                RD_HIGH:
                begin
                    cnt <= cnt + 1'b1;
                    if (cnt == RD_HIGH_CYCLES - 1)
                    begin
                        cnt <= '0;
                        if (chan == ad_chan_t'(AD_CHANNELS - 1))
                            state <= DONE;
                        else
                        begin
                            chan  <= chan + 1'b1;
                            state <= RD_LOW;
                        end
                    end
                end
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Sample buffer, published as one frame
    always_ff @(posedge clk)
    begin
        if (sample_en)
            shadow[chan] <= data_i;
        if (state == DONE && frst_ok)
            chan_q <= shadow;
    end

    always_ff @(posedge clk)
    begin
        if (reset_i)
            ad_reset_o <= 1'b0;
        else
            ad_reset_o <= ad_reset_i;
    end

    // Pin strobes, active low
    assign convst_o = (state != CONVST);
    assign rd_o     = (state != RD_LOW);
    assign csn_o    = (state != RD_LOW);

    // Channel n at page offset n, rest of the page reads 0
    assign rdata_o = (sel_i && reg_addr_i[6:3] == 4'd0) ? chan_q[reg_addr_i[2:0]] : '0;

endmodule

// ==== logic/pwm_ctrl.sv ====
/*
 * Phase accumulator PWM for the speaker
 */
`timescale 1ns/1ps
module pwm_ctrl
    import board_pkg::*;
(
    input  logic   clk,
    input  logic   reset_i,
    input  phase_t ftw_i,
    input  phase_t duty_i,
    input  logic   en_i,
    input  logic   load_i,
    output logic   pwm_o
);

    phase_t ftw_q;
    phase_t duty_q;
    phase_t phase;

    // Words take effect only on load
    always_ff @(posedge clk)
    begin
        if (load_i)
        begin
            ftw_q  <= ftw_i;
            duty_q <= duty_i;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            phase <= '0;
            pwm_o <= 1'b0;
        end
        else if (en_i)
        begin
            phase <= phase + ftw_q;
            pwm_o <= (phase < duty_q);   // High for the duty fraction
        end
        else
        begin
            phase <= '0;
            pwm_o <= 1'b0;
        end
    end

endmodule

// ==== logic/timer.sv ====
/*
 * Millisecond and second tick divider with run indicator
 */
`timescale 1ns/1ps
module timer
    import board_pkg::*;
#(
    parameter int CLK_PER_MS = 80000
)
(
    input  logic clk,
    input  logic reset_i,
    output logic ms_pulse_o,
    output logic second_tick_o,
    output logic run_o
);

    logic [$clog2(CLK_PER_MS)-1:0] clk_cnt;
    logic [$clog2(MS_PER_SEC)-1:0] ms_cnt;

    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            clk_cnt       <= '0;
            ms_cnt        <= '0;
            ms_pulse_o    <= 1'b0;
            second_tick_o <= 1'b0;
            run_o         <= 1'b0;
        end
        else
        begin
            ms_pulse_o    <= 1'b0;
            second_tick_o <= 1'b0;
            if (clk_cnt == CLK_PER_MS - 1)
            begin
                clk_cnt    <= '0;
                ms_pulse_o <= 1'b1;
            end
            else
                clk_cnt <= clk_cnt + 1'b1;

            // Count finished milliseconds
            if (ms_pulse_o)
            begin
                if (ms_cnt == MS_PER_SEC - 1)
                begin
                    ms_cnt        <= '0;
                    second_tick_o <= 1'b1;
                    run_o         <= !run_o;     // Blink once a second
                end
                else
                    ms_cnt <= ms_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== logic/sys_registers.sv ====
/*
 * System register bank: relays, TTL I/O, PWM words,
 * AD7606 control and seconds counter
 */
`timescale 1ns/1ps
module sys_registers
    import board_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,
    input  lbs_addr_t  reg_addr_i,
    input  lbs_data_t  reg_wdata_i,
    input  logic       reg_we_i,
    input  logic       sel_i,
    input  logic [5:0] ttl_i,
    input  logic       second_tick_i,
    output lbs_data_t  rdata_o,
    output logic [3:0] relay_con_o,
    output logic       relay_oen_o,
    output logic [5:0] ttl_o,
    output logic       ttl_en_o,
    output phase_t     pwm_ftw_o,
    output phase_t     pwm_duty_o,
    output logic       pwm_en_o,
    output logic       pwm_load_o,
    output logic       ad_conv_en_o,
    output logic       ad_reset_o
);

    logic       wr_en;
    logic [5:0] ttl_meta;
    logic [5:0] ttl_sync;
    lbs_data_t  sec_cnt;

    assign wr_en = sel_i && reg_we_i;

    // ********************
    // Writable registers
    // ********************
    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            relay_con_o  <= '0;
            relay_oen_o  <= 1'b0;
            ttl_o        <= '0;
            ttl_en_o     <= 1'b0;
            pwm_ftw_o    <= '0;
            pwm_duty_o   <= '0;
            pwm_en_o     <= 1'b0;
            pwm_load_o   <= 1'b0;
            ad_conv_en_o <= 1'b0;
            ad_reset_o   <= 1'b0;
        end
        else
        begin
            // Self clearing load strobe
            pwm_load_o <= wr_en && (reg_addr_i == REG_PWM_CTRL) && reg_wdata_i[1];
            if (wr_en)
            begin
                case (reg_addr_i)
                    REG_RELAY:
                    begin
                        relay_con_o <= reg_wdata_i[3:0];
                        relay_oen_o <= reg_wdata_i[4];
                    end
                    REG_TTL_OUT:
                    begin
                        ttl_o    <= reg_wdata_i[5:0];
                        ttl_en_o <= reg_wdata_i[8];     // Driver enable
                    end
                    REG_FTW_LO:   pwm_ftw_o[15:0]   <= reg_wdata_i;
                    REG_FTW_HI:   pwm_ftw_o[31:16]  <= reg_wdata_i;
                    REG_DUTY_LO:  pwm_duty_o[15:0]  <= reg_wdata_i;
                    REG_DUTY_HI:  pwm_duty_o[31:16] <= reg_wdata_i;
                    REG_PWM_CTRL: pwm_en_o          <= reg_wdata_i[0];
                    REG_AD_CTRL:
                    begin
                        ad_reset_o   <= reg_wdata_i[0];
                        ad_conv_en_o <= reg_wdata_i[1];
                    end
                    default: ;
                endcase
            end
        end
    end

    // Two flop synchronizer for the TTL inputs
    always_ff @(posedge clk)
    begin
        ttl_meta <= ttl_i;
        ttl_sync <= ttl_meta;
    end

    // Uptime in seconds
    always_ff @(posedge clk)
    begin
        if (reset_i)
            sec_cnt <= '0;
        else if (second_tick_i)
            sec_cnt <= sec_cnt + 1'b1;
    end

    // ********************
    // Read mux
    // ********************
    always_comb
    begin
        rdata_o = '0;
        if (sel_i)
        begin
            case (reg_addr_i)
                REG_ID:       rdata_o = BOARD_ID;
                REG_RELAY:    rdata_o = {11'd0, relay_oen_o, relay_con_o};
                REG_TTL_OUT:  rdata_o = {7'd0, ttl_en_o, 2'd0, ttl_o};
                REG_TTL_IN:   rdata_o = {10'd0, ttl_sync};
                REG_FTW_LO:   rdata_o = pwm_ftw_o[15:0];
                REG_FTW_HI:   rdata_o = pwm_ftw_o[31:16];
                REG_DUTY_LO:  rdata_o = pwm_duty_o[15:0];
                REG_DUTY_HI:  rdata_o = pwm_duty_o[31:16];
                REG_PWM_CTRL: rdata_o = {15'd0, pwm_en_o};   // Load bit reads 0
                REG_AD_CTRL:  rdata_o = {14'd0, ad_conv_en_o, ad_reset_o};
                REG_SEC_CNT:  rdata_o = sec_cnt;
                default:      rdata_o = '0;
            endcase
        end
    end

endmodule

// ==== logic/lbs_ctrl.sv ====
/*
 * Local bus controller: access register stage, page decode
 * and registered read data return
 */
`timescale 1ns/1ps
module lbs_ctrl
    import board_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      lbs_cs_n_i,
    input  logic      lbs_we_i,
    input  logic      lbs_re_i,
    input  lbs_addr_t lbs_addr_i,
    input  lbs_data_t lbs_wdata_i,
    input  lbs_data_t sys_rdata_i,
    input  lbs_data_t ad_rdata_i,
    output lbs_addr_t reg_addr_o,
    output lbs_data_t reg_wdata_o,
    output logic      reg_we_o,
    output logic      sys_sel_o,
    output logic      ad_sel_o,
    output lbs_data_t lbs_rdata_o
);

    logic wr_acc;
    logic rd_acc;
    logic reg_re;

    // Strobes only count with chip select low
    assign wr_acc = lbs_we_i && !lbs_cs_n_i;
    assign rd_acc = lbs_re_i && !lbs_cs_n_i;

    // Address and data stage
    always_ff @(posedge clk)
    begin
        reg_addr_o  <= lbs_addr_i;
        reg_wdata_o <= lbs_wdata_i;
    end

    // Strobes and page select
    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            reg_we_o  <= 1'b0;
            reg_re    <= 1'b0;
            sys_sel_o <= 1'b0;
            ad_sel_o  <= 1'b0;
        end
        else
        begin
            reg_we_o  <= wr_acc;
            reg_re    <= rd_acc;
            sys_sel_o <= (wr_acc || rd_acc) && !lbs_addr_i[AD_PAGE_BIT];
            ad_sel_o  <= (wr_acc || rd_acc) && lbs_addr_i[AD_PAGE_BIT];
        end
    end

    // Second cycle of a read, held until the next one
    always_ff @(posedge clk)
    begin
        if (reset_i)
            lbs_rdata_o <= '0;
        else if (reg_re)
            lbs_rdata_o <= ad_sel_o ? ad_rdata_i : sys_rdata_i;
    end

endmodule

// ==== logic/board_pkg.sv ====
/*
 * Shared types, register map, AD7606 timing and settings,
 * sequencer state encoding
 */
package board_pkg;

    // ********************
    // Types
    // ********************
    typedef logic [7:0]  lbs_addr_t;           // Local bus register address
    typedef logic [15:0] lbs_data_t;           // Local bus data word
    typedef logic [15:0] ad_sample_t;          // One AD7606 result
    typedef logic [2:0]  ad_chan_t;            // Channel index
    typedef logic [31:0] phase_t;              // PWM tuning, duty and accumulator

    typedef enum logic [2:0] {
        IDLE,
        CONVST,
        WAIT_BUSY_HI,
        WAIT_BUSY_LO,
        RD_LOW,
        RD_HIGH,
        DONE
    } ad_state_t;

    // ********************
    // Register map
    // ********************
    localparam int        AD_PAGE_BIT  = 7;    // Set selects the AD7606 page
    localparam lbs_addr_t REG_ID       = 8'h00;
    localparam lbs_data_t BOARD_ID     = 16'h7606;
    localparam lbs_addr_t REG_RELAY    = 8'h01;
    localparam lbs_addr_t REG_TTL_OUT  = 8'h02;
    localparam lbs_addr_t REG_TTL_IN   = 8'h03;
    localparam lbs_addr_t REG_FTW_LO   = 8'h04;
    localparam lbs_addr_t REG_FTW_HI   = 8'h05;
    localparam lbs_addr_t REG_DUTY_LO  = 8'h06;
    localparam lbs_addr_t REG_DUTY_HI  = 8'h07;
    localparam lbs_addr_t REG_PWM_CTRL = 8'h08;
    localparam lbs_addr_t REG_AD_CTRL  = 8'h09;
    localparam lbs_addr_t REG_SEC_CNT  = 8'h0A;

    // Timer
    localparam int MS_PER_SEC = 1000;

    // ********************
    // AD7606
    // ********************
    localparam int         AD_CHANNELS       = 8;
    localparam int         CONVST_LOW_CYCLES = 4;
    localparam int         RD_LOW_CYCLES     = 3;
    localparam int         RD_HIGH_CYCLES    = 2;
    localparam int         BUSY_TIMEOUT      = 4096;
    localparam logic [2:0] AD_OS_SETTING     = 3'd0;   // No oversampling
    localparam logic       AD_RANGE_SETTING  = 1'b1;   // +/-10 V
    localparam logic       AD_REF_SETTING    = 1'b1;   // Internal reference

endpackage
